//--- hart.f
source/hart_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/hazard_unit.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/hart.sv
verification/hart_monitor.sv
verification/hart_sva.sv
verification/tb_hart.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_hart -f hart.f -o tb_hart_sim
./obj_dir/tb_hart_sim > sim.log 2>&1 || true
cat sim.log
if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
  exit 1
fi
exit 0

//--- verification/tb_hart.sv
`timescale 1ns/1ns
`default_nettype none
module tb_hart;
  localparam int PROG_WORDS = 27;
  localparam int HALT_TIMEOUT = 300; // cycles, far beyond the program's stalls and bubbles
  localparam int MON_ROWS = 20;

  logic i_clk;
  logic i_rst;
  hart_pkg::word_t i_imem_rdata, i_dmem_rdata;
  hart_pkg::word_t o_imem_raddr, o_dmem_addr, o_dmem_wdata;
  logic o_dmem_ren, o_dmem_wen;
  logic o_retire_valid, o_retire_halt;
  hart_pkg::word_t o_retire_inst, o_retire_rs1_rdata, o_retire_rs2_rdata;
  hart_pkg::word_t o_retire_rd_wdata, o_retire_pc, o_retire_next_pc;
  hart_pkg::reg_addr_t o_retire_rs1_raddr, o_retire_rs2_raddr, o_retire_rd_waddr;
  int mon_errors, mon_rows, tb_errors;
  logic halted;

  hart_pkg::word_t imem [256];
  hart_pkg::word_t dmem [256];

  // program image, one word per address from zero, skipped slots load x12
  hart_pkg::word_t program_words [PROG_WORDS] = '{
    32'h00500093, 32'hFFD08113, 32'h002081B3, 32'h40310233, 32'h001242B3,
    32'h00122333, 32'h406253B3, 32'h12345437, 32'h00001497, 32'h00302823,
    32'h01002503, 32'h00900013, 32'h00A005B3, 32'h00208463, 32'h00209663,
    32'h00100613, 32'h00200613, 32'h00C006EF, 32'h00300613, 32'h00400613,
    32'h06000713, 32'h000707E7, 32'h00300613, 32'h00400613, 32'h00124463,
    32'h00500613, 32'h00100073
  };

  hart DUT (.*);

  hart_monitor u_monitor (
    .i_clk, .i_rst, .i_retire_valid(o_retire_valid), .i_retire_halt(o_retire_halt),
    .i_retire_inst(o_retire_inst), .i_retire_pc(o_retire_pc),
    .i_retire_next_pc(o_retire_next_pc), .i_retire_rd_waddr(o_retire_rd_waddr),
    .i_retire_rd_wdata(o_retire_rd_wdata), .i_retire_rs1_raddr(o_retire_rs1_raddr),
    .i_retire_rs2_raddr(o_retire_rs2_raddr), .i_retire_rs1_rdata(o_retire_rs1_rdata),
    .i_retire_rs2_rdata(o_retire_rs2_rdata), .o_errors(mon_errors), .o_rows_done(mon_rows)
  );

  always #10 i_clk = ~i_clk;

  // both memories register at the edge and drive their data a short delay later
  always @(posedge i_clk) begin
    i_imem_rdata <= #2 imem[o_imem_raddr[9:2]];
    if (o_dmem_wen) dmem[o_dmem_addr[9:2]] = o_dmem_wdata; // write lands at the edge
    if (o_dmem_ren) i_dmem_rdata <= #2 dmem[o_dmem_addr[9:2]];
  end

  initial begin
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_imem_rdata = '0;
    i_dmem_rdata = '0;
    tb_errors = 0;
    halted = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = hart_pkg::NOP_INST;
      dmem[i] = 32'hD0A7_0000 ^ (i << 2); // pattern tied to the byte address
    end
    for (int i = 0; i < PROG_WORDS; i++) begin
      imem[i] = program_words[i];
    end
    repeat (3) @(posedge i_clk);
    #2 i_rst = 1'b0;

    // wait for the ebreak retirement, bounded
    for (int c = 0; c < HALT_TIMEOUT && !halted; c++) begin
      @(negedge i_clk);
      if (o_retire_halt) halted = 1'b1;
    end
    @(posedge i_clk); // lets the monitor finish the halt row

    if (!halted) begin
      $display("hart did not halt before timeout");
      tb_errors++;
    end else if (mon_rows != MON_ROWS) begin
      $display("hart halted after %0d of %0d expected retirements", mon_rows, MON_ROWS);
      tb_errors++;
    end
    $display("errors: monitor %0d, testbench %0d", mon_errors, tb_errors);
    if (mon_errors == 0 && tb_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end
endmodule
`default_nettype wire

//--- verification/hart_sva.sv
`timescale 1ns/1ns
`default_nettype none
module hart_sva (
  input wire i_clk,
  input wire i_rst,
  input wire hart_pkg::word_t o_imem_raddr,
  input wire o_dmem_ren,
  input wire o_dmem_wen,
  input wire o_retire_valid,
  input wire o_retire_halt
);
  // a single data port slot carries either a load or a store
  a_ren_wen_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_dmem_ren && o_dmem_wen)) else $error("dmem read and write enabled together");

  a_imem_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    o_imem_raddr[1:0] == 2'b00) else $error("imem address not word aligned");

  // retire stays quiet on the cycle after any reset edge
  a_no_retire_in_reset: assert property (@(posedge i_clk)
    i_rst |=> !o_retire_valid) else $error("retire valid while in reset");

  a_halt_needs_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_retire_halt |-> o_retire_valid) else $error("halt without retire valid");
endmodule

bind hart hart_sva u_sva (
  .i_clk, .i_rst, .o_imem_raddr, .o_dmem_ren, .o_dmem_wen, .o_retire_valid, .o_retire_halt
);
`default_nettype wire

//--- verification/hart_monitor.sv
`timescale 1ns/1ns
`default_nettype none
module hart_monitor (
  input wire i_clk,
  input wire i_rst,
  input wire i_retire_valid,
  input wire i_retire_halt,
  input wire hart_pkg::word_t i_retire_inst,
  input wire hart_pkg::word_t i_retire_pc,
  input wire hart_pkg::word_t i_retire_next_pc,
  input wire hart_pkg::reg_addr_t i_retire_rd_waddr,
  input wire hart_pkg::word_t i_retire_rd_wdata,
  input wire hart_pkg::reg_addr_t i_retire_rs1_raddr,
  input wire hart_pkg::reg_addr_t i_retire_rs2_raddr,
  input wire hart_pkg::word_t i_retire_rs1_rdata,
  input wire hart_pkg::word_t i_retire_rs2_rdata,
  output int o_errors,
  output int o_rows_done
);
  localparam int ROWS = 20;

  hart_pkg::word_t exp_pc [ROWS];
  hart_pkg::word_t exp_inst [ROWS];
  hart_pkg::reg_addr_t exp_rd [ROWS];
  hart_pkg::word_t exp_wdata [ROWS]; // only compared when the row writes a register
  hart_pkg::word_t exp_next [ROWS];
  hart_pkg::reg_addr_t exp_rs1 [ROWS]; // zero when the instruction reads no rs1
  hart_pkg::word_t exp_rs1_data [ROWS];
  hart_pkg::reg_addr_t exp_rs2 [ROWS];
  hart_pkg::word_t exp_rs2_data [ROWS];

  task automatic set_row(input int k, input hart_pkg::word_t pc, input hart_pkg::word_t inst,
                         input hart_pkg::reg_addr_t rd, input hart_pkg::word_t wdata,
                         input hart_pkg::word_t next_pc);
    exp_pc[k] = pc;
    exp_inst[k] = inst;
    exp_rd[k] = rd;
    exp_wdata[k] = wdata;
    exp_next[k] = next_pc;
  endtask

  task automatic set_sources(input int k, input hart_pkg::reg_addr_t rs1,
                             input hart_pkg::word_t rs1_data, input hart_pkg::reg_addr_t rs2,
                             input hart_pkg::word_t rs2_data);
    exp_rs1[k] = rs1;
    exp_rs1_data[k] = rs1_data;
    exp_rs2[k] = rs2;
    exp_rs2_data[k] = rs2_data;
  endtask

  // each row follows from RV32I rules applied by hand to the program in tb_hart
  initial begin
    o_errors = 0;
    o_rows_done = 0;
    set_row(0, 32'h00, 32'h00500093, 5'd1, 32'h00000005, 32'h04); // addi x1, x0, 5
    set_row(1, 32'h04, 32'hFFD08113, 5'd2, 32'h00000002, 32'h08); // addi x2, x1, -3
    set_row(2, 32'h08, 32'h002081B3, 5'd3, 32'h00000007, 32'h0C); // add x3, x1, x2
    set_row(3, 32'h0C, 32'h40310233, 5'd4, 32'hFFFFFFFB, 32'h10); // sub gives -5
    set_row(4, 32'h10, 32'h001242B3, 5'd5, 32'hFFFFFFFE, 32'h14); // xor
    set_row(5, 32'h14, 32'h00122333, 5'd6, 32'h00000001, 32'h18); // slt, -5 < 5
    set_row(6, 32'h18, 32'h406253B3, 5'd7, 32'hFFFFFFFD, 32'h1C); // sra -5 by 1
    set_row(7, 32'h1C, 32'h12345437, 5'd8, 32'h12345000, 32'h20); // lui
    set_row(8, 32'h20, 32'h00001497, 5'd9, 32'h00001020, 32'h24); // auipc adds its pc
    set_row(9, 32'h24, 32'h00302823, 5'd0, 32'h0, 32'h28); // sw x3 to address 16
    set_row(10, 32'h28, 32'h01002503, 5'd10, 32'h00000007, 32'h2C); // lw reads the store back
    set_row(11, 32'h2C, 32'h00900013, 5'd0, 32'h0, 32'h30); // targets x0
    set_row(12, 32'h30, 32'h00A005B3, 5'd11, 32'h00000007, 32'h34); // x0 still reads zero
    set_row(13, 32'h34, 32'h00208463, 5'd0, 32'h0, 32'h38); // beq not taken falls through
    set_row(14, 32'h38, 32'h00209663, 5'd0, 32'h0, 32'h44); // bne taken
    set_row(15, 32'h44, 32'h00C006EF, 5'd13, 32'h00000048, 32'h50); // jal links pc plus four
    set_row(16, 32'h50, 32'h06000713, 5'd14, 32'h00000060, 32'h54);
    set_row(17, 32'h54, 32'h000707E7, 5'd15, 32'h00000058, 32'h60); // jalr through x14
    set_row(18, 32'h60, 32'h00124463, 5'd0, 32'h0, 32'h68); // blt taken
    set_row(19, 32'h68, 32'h00100073, 5'd0, 32'h0, 32'h6C); // ebreak halts

    // source registers, unread ones report address and data zero
    set_sources(0, 5'd0, 32'h0, 5'd0, 32'h0);
    set_sources(1, 5'd1, 32'h5, 5'd0, 32'h0); // the rs2 field holds 29 but is unread
    set_sources(2, 5'd1, 32'h5, 5'd2, 32'h2);
    set_sources(3, 5'd2, 32'h2, 5'd3, 32'h7);
    set_sources(4, 5'd4, 32'hFFFFFFFB, 5'd1, 32'h5);
    set_sources(5, 5'd4, 32'hFFFFFFFB, 5'd1, 32'h5);
    set_sources(6, 5'd4, 32'hFFFFFFFB, 5'd6, 32'h1);
    set_sources(7, 5'd0, 32'h0, 5'd0, 32'h0); // lui and auipc read no register
    set_sources(8, 5'd0, 32'h0, 5'd0, 32'h0);
    set_sources(9, 5'd0, 32'h0, 5'd3, 32'h7); // store data comes from rs2
    set_sources(10, 5'd0, 32'h0, 5'd0, 32'h0);
    set_sources(11, 5'd0, 32'h0, 5'd0, 32'h0);
    set_sources(12, 5'd0, 32'h0, 5'd10, 32'h7);
    set_sources(13, 5'd1, 32'h5, 5'd2, 32'h2);
    set_sources(14, 5'd1, 32'h5, 5'd2, 32'h2);
    set_sources(15, 5'd0, 32'h0, 5'd0, 32'h0);
    set_sources(16, 5'd0, 32'h0, 5'd0, 32'h0);
    set_sources(17, 5'd14, 32'h60, 5'd0, 32'h0);
    set_sources(18, 5'd4, 32'hFFFFFFFB, 5'd1, 32'h5);
    set_sources(19, 5'd0, 32'h0, 5'd0, 32'h0);
  end

  task automatic mismatch(input string field, input hart_pkg::word_t got,
                          input hart_pkg::word_t want);
    $display("Mismatch at %0t: row %0d %s got %h expected %h", $time, o_rows_done, field,
             got, want);
    o_errors++;
  endtask

  // retire outputs settle after the rising edge, so the falling edge sees them stable
  always @(negedge i_clk) begin
    if (!i_rst && i_retire_valid) begin
      if (o_rows_done >= ROWS) begin
        $display("hart retired an instruction after the last expected row at %0t", $time);
        o_errors++;
      end else begin
        if (i_retire_pc !== exp_pc[o_rows_done]) mismatch("pc", i_retire_pc, exp_pc[o_rows_done]);
        if (i_retire_inst !== exp_inst[o_rows_done])
          mismatch("inst", i_retire_inst, exp_inst[o_rows_done]);
        if (i_retire_rd_waddr !== exp_rd[o_rows_done])
          mismatch("rd_waddr", 32'(i_retire_rd_waddr), 32'(exp_rd[o_rows_done]));
        if (exp_rd[o_rows_done] != '0 && i_retire_rd_wdata !== exp_wdata[o_rows_done])
          mismatch("rd_wdata", i_retire_rd_wdata, exp_wdata[o_rows_done]);
        if (i_retire_next_pc !== exp_next[o_rows_done])
          mismatch("next_pc", i_retire_next_pc, exp_next[o_rows_done]);
        if (i_retire_rs1_raddr !== exp_rs1[o_rows_done])
          mismatch("rs1_raddr", 32'(i_retire_rs1_raddr), 32'(exp_rs1[o_rows_done]));
        if (i_retire_rs1_rdata !== exp_rs1_data[o_rows_done])
          mismatch("rs1_rdata", i_retire_rs1_rdata, exp_rs1_data[o_rows_done]);
        if (i_retire_rs2_raddr !== exp_rs2[o_rows_done])
          mismatch("rs2_raddr", 32'(i_retire_rs2_raddr), 32'(exp_rs2[o_rows_done]));
        if (i_retire_rs2_rdata !== exp_rs2_data[o_rows_done])
          mismatch("rs2_rdata", i_retire_rs2_rdata, exp_rs2_data[o_rows_done]);
        if (i_retire_halt !== (o_rows_done == ROWS - 1)) // only the final ebreak halts
          mismatch("halt", 32'(i_retire_halt), 32'(o_rows_done == ROWS - 1));
        o_rows_done++;
      end
    end
  end
endmodule
`default_nettype wire

//--- source/hart.sv
`timescale 1ns/1ns
`default_nettype none
module hart (
  input wire i_clk,
  input wire i_rst,
  output hart_pkg::word_t o_imem_raddr,
  input wire hart_pkg::word_t i_imem_rdata,
  output hart_pkg::word_t o_dmem_addr,
  output logic o_dmem_ren,
  output logic o_dmem_wen,
  output hart_pkg::word_t o_dmem_wdata,
  input wire hart_pkg::word_t i_dmem_rdata,
  output logic o_retire_valid,
  output hart_pkg::word_t o_retire_inst,
  output logic o_retire_halt,
  output hart_pkg::reg_addr_t o_retire_rs1_raddr,
  output hart_pkg::reg_addr_t o_retire_rs2_raddr,
  output hart_pkg::word_t o_retire_rs1_rdata,
  output hart_pkg::word_t o_retire_rs2_rdata,
  output hart_pkg::reg_addr_t o_retire_rd_waddr,
  output hart_pkg::word_t o_retire_rd_wdata,
  output hart_pkg::word_t o_retire_pc,
  output hart_pkg::word_t o_retire_next_pc
);
  wire stall, redirect, if_valid, id_valid, ex_valid;
  wire hart_pkg::word_t redirect_pc, if_pc, if_inst, rs1_rdata, rs2_rdata;
  wire hart_pkg::reg_addr_t rs1_raddr, rs2_raddr, id_rd, ex_rd, rd_waddr, wb_rd;
  wire hart_pkg::word_t id_pc, id_inst, id_rs1_rdata, id_rs2_rdata, id_imm;
  wire hart_pkg::alu_op_e id_alu_op;
  wire hart_pkg::wb_sel_e id_wb_sel, ex_wb_sel;
  wire id_use_imm, id_use_pc, id_reg_write, id_mem_read, id_mem_write;
  wire id_branch, id_jal, id_jalr;
  wire hart_pkg::word_t ex_pc, ex_next_pc, ex_inst, ex_rs1_rdata, ex_rs2_rdata, ex_alu_result;
  wire ex_reg_write, ex_mem_read, ex_mem_write;
  wire rd_wen, wb_reg_write; // writeback port and the memory-stage hazard source
  wire hart_pkg::word_t rd_wdata;

  fetch_stage u_fetch (
    .i_clk, .i_rst, .i_stall(stall), .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .i_imem_rdata, .o_imem_raddr, .o_if_valid(if_valid), .o_if_pc(if_pc), .o_if_inst(if_inst)
  );

  decode_stage u_decode (
    .i_clk, .i_rst, .i_stall(stall), .i_flush(redirect), .i_if_valid(if_valid),
    .i_if_pc(if_pc), .i_if_inst(if_inst), .i_rs1_rdata(rs1_rdata), .i_rs2_rdata(rs2_rdata),
    .o_rs1_raddr(rs1_raddr), .o_rs2_raddr(rs2_raddr), .o_id_valid(id_valid),
    .o_id_pc(id_pc), .o_id_inst(id_inst), .o_id_rs1_rdata(id_rs1_rdata),
    .o_id_rs2_rdata(id_rs2_rdata), .o_id_imm(id_imm), .o_id_alu_op(id_alu_op),
    .o_id_wb_sel(id_wb_sel), .o_id_use_imm(id_use_imm), .o_id_use_pc(id_use_pc),
    .o_id_reg_write(id_reg_write), .o_id_mem_read(id_mem_read),
    .o_id_mem_write(id_mem_write), .o_id_branch(id_branch), .o_id_jal(id_jal),
    .o_id_jalr(id_jalr), .o_id_rd(id_rd)
  );

  reg_file u_regs (
    .i_clk, .i_rst, .i_rs1_raddr(rs1_raddr), .i_rs2_raddr(rs2_raddr),
    .o_rs1_rdata(rs1_rdata), .o_rs2_rdata(rs2_rdata),
    .i_rd_waddr(rd_waddr), .i_rd_wen(rd_wen), .i_rd_wdata(rd_wdata)
  );

  // execute sees the ID/EX contents, memory sees EX/MEM
  hazard_unit u_hazard (
    .i_rs1_raddr(rs1_raddr), .i_rs2_raddr(rs2_raddr),
    .i_ex_rd(id_rd), .i_ex_reg_write(id_reg_write),
    .i_mem_rd(wb_rd), .i_mem_reg_write(wb_reg_write), .o_stall(stall)
  );

  execute_stage u_execute (
    .i_clk, .i_rst, .i_id_valid(id_valid), .i_id_pc(id_pc), .i_id_inst(id_inst),
    .i_id_rs1_rdata(id_rs1_rdata), .i_id_rs2_rdata(id_rs2_rdata), .i_id_imm(id_imm),
    .i_id_alu_op(id_alu_op), .i_id_wb_sel(id_wb_sel), .i_id_use_imm(id_use_imm),
    .i_id_use_pc(id_use_pc), .i_id_reg_write(id_reg_write), .i_id_mem_read(id_mem_read),
    .i_id_mem_write(id_mem_write), .i_id_branch(id_branch), .i_id_jal(id_jal),
    .i_id_jalr(id_jalr), .i_id_rd(id_rd), .o_redirect(redirect), .o_redirect_pc(redirect_pc),
    .o_ex_valid(ex_valid), .o_ex_pc(ex_pc), .o_ex_next_pc(ex_next_pc), .o_ex_inst(ex_inst),
    .o_ex_rs1_rdata(ex_rs1_rdata), .o_ex_rs2_rdata(ex_rs2_rdata),
    .o_ex_alu_result(ex_alu_result), .o_ex_wb_sel(ex_wb_sel), .o_ex_reg_write(ex_reg_write),
    .o_ex_mem_read(ex_mem_read), .o_ex_mem_write(ex_mem_write), .o_ex_rd(ex_rd)
  );

  mem_wb_stage u_mem_wb (
    .i_clk, .i_rst, .i_ex_valid(ex_valid), .i_ex_pc(ex_pc), .i_ex_next_pc(ex_next_pc),
    .i_ex_inst(ex_inst), .i_ex_rs1_rdata(ex_rs1_rdata), .i_ex_rs2_rdata(ex_rs2_rdata),
    .i_ex_alu_result(ex_alu_result), .i_ex_wb_sel(ex_wb_sel), .i_ex_reg_write(ex_reg_write),
    .i_ex_mem_read(ex_mem_read), .i_ex_mem_write(ex_mem_write), .i_ex_rd(ex_rd),
    .i_dmem_rdata, .o_dmem_addr, .o_dmem_ren, .o_dmem_wen, .o_dmem_wdata,
    .o_rd_waddr(rd_waddr), .o_rd_wen(rd_wen), .o_rd_wdata(rd_wdata),
    .o_wb_rd(wb_rd), .o_wb_reg_write(wb_reg_write),
    .o_retire_valid, .o_retire_inst, .o_retire_halt, .o_retire_rs1_raddr,
    .o_retire_rs2_raddr, .o_retire_rs1_rdata, .o_retire_rs2_rdata, .o_retire_rd_waddr,
    .o_retire_rd_wdata, .o_retire_pc, .o_retire_next_pc
  );
endmodule
`default_nettype wire

//--- source/mem_wb_stage.sv
`timescale 1ns/1ns
`default_nettype none
module mem_wb_stage (
  input wire i_clk,
  input wire i_rst,
  input wire i_ex_valid,
  input wire hart_pkg::word_t i_ex_pc,
  input wire hart_pkg::word_t i_ex_next_pc,
  input wire hart_pkg::word_t i_ex_inst,
  input wire hart_pkg::word_t i_ex_rs1_rdata,
  input wire hart_pkg::word_t i_ex_rs2_rdata,
  input wire hart_pkg::word_t i_ex_alu_result,
  input wire hart_pkg::wb_sel_e i_ex_wb_sel,
  input wire i_ex_reg_write,
  input wire i_ex_mem_read,
  input wire i_ex_mem_write,
  input wire hart_pkg::reg_addr_t i_ex_rd,
  input wire hart_pkg::word_t i_dmem_rdata,
  output hart_pkg::word_t o_dmem_addr,
  output logic o_dmem_ren,
  output logic o_dmem_wen,
  output hart_pkg::word_t o_dmem_wdata,
  output hart_pkg::reg_addr_t o_rd_waddr,
  output logic o_rd_wen,
  output hart_pkg::word_t o_rd_wdata,
  output hart_pkg::reg_addr_t o_wb_rd,
  output logic o_wb_reg_write,
  output logic o_retire_valid,
  output hart_pkg::word_t o_retire_inst,
  output logic o_retire_halt,
  output hart_pkg::reg_addr_t o_retire_rs1_raddr,
  output hart_pkg::reg_addr_t o_retire_rs2_raddr,
  output hart_pkg::word_t o_retire_rs1_rdata,
  output hart_pkg::word_t o_retire_rs2_rdata,
  output hart_pkg::reg_addr_t o_retire_rd_waddr,
  output hart_pkg::word_t o_retire_rd_wdata,
  output hart_pkg::word_t o_retire_pc,
  output hart_pkg::word_t o_retire_next_pc
);
  logic valid_q, reg_write_q;
  hart_pkg::word_t pc_q, next_pc_q, inst_q, rs1_q, rs2_q, alu_q, wb_data;
  hart_pkg::wb_sel_e wb_sel_q;
  hart_pkg::reg_addr_t rd_q;

  assign o_dmem_addr = {i_ex_alu_result[31:2], 2'b00}; // word access only
  assign o_dmem_ren = i_ex_valid && i_ex_mem_read; // a load and a store never share a slot
  assign o_dmem_wen = i_ex_valid && i_ex_mem_write;
  assign o_dmem_wdata = i_ex_rs2_rdata;

  // destination still headed for writeback, the hazard unit waits on it
  assign o_wb_rd = i_ex_rd;
  assign o_wb_reg_write = i_ex_valid && i_ex_reg_write;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
      reg_write_q <= 1'b0;
    end else begin
      valid_q <= i_ex_valid;
      reg_write_q <= i_ex_reg_write;
    end
  end

  always_ff @(posedge i_clk) begin
    pc_q <= i_ex_pc;
    next_pc_q <= i_ex_next_pc;
    inst_q <= i_ex_inst;
    rs1_q <= i_ex_rs1_rdata;
    rs2_q <= i_ex_rs2_rdata;
    alu_q <= i_ex_alu_result;
    wb_sel_q <= i_ex_wb_sel;
    rd_q <= i_ex_rd;
  end

  always_comb begin
    case (wb_sel_q)
      hart_pkg::WB_LOAD: wb_data = i_dmem_rdata; // the read lands in this cycle
      hart_pkg::WB_PC4: wb_data = pc_q + 32'd4;
      default: wb_data = alu_q;
    endcase
  end

  assign o_rd_waddr = rd_q;
  assign o_rd_wen = valid_q && reg_write_q;
  assign o_rd_wdata = wb_data;

  assign o_retire_valid = valid_q;
  assign o_retire_inst = inst_q;
  assign o_retire_halt = inst_q == hart_pkg::EBREAK_INST; // bubbles carry NOP_INST
  assign o_retire_rs1_raddr = hart_pkg::reads_rs1(inst_q[6:0]) ? inst_q[19:15] : '0;
  assign o_retire_rs2_raddr = hart_pkg::reads_rs2(inst_q[6:0]) ? inst_q[24:20] : '0;
  assign o_retire_rs1_rdata = rs1_q; // zero already for unread sources
  assign o_retire_rs2_rdata = rs2_q;
  assign o_retire_rd_waddr = rd_q;
  assign o_retire_rd_wdata = wb_data;
  assign o_retire_pc = pc_q;
  assign o_retire_next_pc = next_pc_q;
endmodule
`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none
module execute_stage (
  input wire i_clk,
  input wire i_rst,
  input wire i_id_valid,
  input wire hart_pkg::word_t i_id_pc,
  input wire hart_pkg::word_t i_id_inst,
  input wire hart_pkg::word_t i_id_rs1_rdata,
  input wire hart_pkg::word_t i_id_rs2_rdata,
  input wire hart_pkg::word_t i_id_imm,
  input wire hart_pkg::alu_op_e i_id_alu_op,
  input wire hart_pkg::wb_sel_e i_id_wb_sel,
  input wire i_id_use_imm,
  input wire i_id_use_pc,
  input wire i_id_reg_write,
  input wire i_id_mem_read,
  input wire i_id_mem_write,
  input wire i_id_branch,
  input wire i_id_jal,
  input wire i_id_jalr,
  input wire hart_pkg::reg_addr_t i_id_rd,
  output logic o_redirect,
  output hart_pkg::word_t o_redirect_pc,
  output logic o_ex_valid,
  output hart_pkg::word_t o_ex_pc,
  output hart_pkg::word_t o_ex_next_pc,
  output hart_pkg::word_t o_ex_inst,
  output hart_pkg::word_t o_ex_rs1_rdata,
  output hart_pkg::word_t o_ex_rs2_rdata,
  output hart_pkg::word_t o_ex_alu_result,
  output hart_pkg::wb_sel_e o_ex_wb_sel,
  output logic o_ex_reg_write,
  output logic o_ex_mem_read,
  output logic o_ex_mem_write,
  output hart_pkg::reg_addr_t o_ex_rd
);
  hart_pkg::word_t op_a, op_b, alu_res, target;
  logic cond; // branch compare result for funct3
  logic taken;

  assign op_a = i_id_use_pc ? i_id_pc : i_id_rs1_rdata;
  assign op_b = i_id_use_imm ? i_id_imm : i_id_rs2_rdata;

  always_comb begin
    case (i_id_alu_op)
      hart_pkg::ALU_ADD: alu_res = op_a + op_b;
      hart_pkg::ALU_SUB: alu_res = op_a - op_b;
      hart_pkg::ALU_SLL: alu_res = op_a << op_b[4:0]; // only the low five bits shift
      hart_pkg::ALU_SLT: alu_res = {{(hart_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      hart_pkg::ALU_SLTU: alu_res = {{(hart_pkg::XLEN-1){1'b0}}, op_a < op_b};
      hart_pkg::ALU_XOR: alu_res = op_a ^ op_b;
      hart_pkg::ALU_SRL: alu_res = op_a >> op_b[4:0];
      hart_pkg::ALU_SRA: alu_res = $signed(op_a) >>> op_b[4:0];
      hart_pkg::ALU_OR: alu_res = op_a | op_b;
      hart_pkg::ALU_AND: alu_res = op_a & op_b;
      default: alu_res = op_b; // pass-B carries the lui immediate
    endcase
  end

  always_comb begin
    case (i_id_inst[14:12])
      3'b000: cond = i_id_rs1_rdata == i_id_rs2_rdata;
      3'b001: cond = i_id_rs1_rdata != i_id_rs2_rdata;
      3'b100: cond = $signed(i_id_rs1_rdata) < $signed(i_id_rs2_rdata);
      3'b101: cond = $signed(i_id_rs1_rdata) >= $signed(i_id_rs2_rdata);
      3'b110: cond = i_id_rs1_rdata < i_id_rs2_rdata;
      3'b111: cond = i_id_rs1_rdata >= i_id_rs2_rdata;
      default: cond = 1'b0; // reserved encodings fall through
    endcase
  end

  assign taken = (i_id_branch && cond) || i_id_jal || i_id_jalr;
  assign target = i_id_jalr ? ((i_id_rs1_rdata + i_id_imm) & ~32'd1) : i_id_pc + i_id_imm;
  assign o_redirect = i_id_valid && taken; // bubbles carry no jump flags, valid guards anyway
  assign o_redirect_pc = target;

  // EX/MEM control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      {o_ex_valid, o_ex_reg_write, o_ex_mem_read, o_ex_mem_write} <= '0;
    end else begin
      {o_ex_valid, o_ex_reg_write, o_ex_mem_read, o_ex_mem_write} <=
        {i_id_valid, i_id_reg_write, i_id_mem_read, i_id_mem_write};
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_pc <= i_id_pc;
    o_ex_next_pc <= taken ? target : i_id_pc + 32'd4; // reported as next pc at retire
    o_ex_inst <= i_id_inst;
    o_ex_rs1_rdata <= i_id_rs1_rdata;
    o_ex_rs2_rdata <= i_id_rs2_rdata; // also the store data
    o_ex_alu_result <= alu_res;
    o_ex_wb_sel <= i_id_wb_sel;
    o_ex_rd <= i_id_rd;
  end
endmodule
`default_nettype wire

//--- source/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none
module hazard_unit (
  input wire hart_pkg::reg_addr_t i_rs1_raddr,
  input wire hart_pkg::reg_addr_t i_rs2_raddr,
  input wire hart_pkg::reg_addr_t i_ex_rd,
  input wire i_ex_reg_write,
  input wire hart_pkg::reg_addr_t i_mem_rd,
  input wire i_mem_reg_write,
  output logic o_stall
);
  // without forwarding a source waits until its producer reaches writeback
  // loads need no extra case since their data also arrives in writeback
  function automatic logic waits_on(input hart_pkg::reg_addr_t rs);
    return (rs != '0) &&
           ((i_ex_reg_write && rs == i_ex_rd) || (i_mem_reg_write && rs == i_mem_rd));
  endfunction

  always_comb begin
    o_stall = waits_on(i_rs1_raddr) || waits_on(i_rs2_raddr);
  end
endmodule
`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ns
`default_nettype none
module reg_file (
  input wire i_clk,
  input wire i_rst,
  input wire hart_pkg::reg_addr_t i_rs1_raddr,
  input wire hart_pkg::reg_addr_t i_rs2_raddr,
  output hart_pkg::word_t o_rs1_rdata,
  output hart_pkg::word_t o_rs2_rdata,
  input wire hart_pkg::reg_addr_t i_rd_waddr,
  input wire i_rd_wen,
  input wire hart_pkg::word_t i_rd_wdata
);
  hart_pkg::word_t regs [1:31]; // x0 has no storage

  // a same-cycle write is passed through, the writeback stage needs no forwarding
  function automatic hart_pkg::word_t read_port(input hart_pkg::reg_addr_t addr);
    if (addr == '0) return '0;
    if (i_rd_wen && i_rd_waddr == addr) return i_rd_wdata;
    return regs[addr];
  endfunction

  always_comb begin
    o_rs1_rdata = read_port(i_rs1_raddr);
    o_rs2_rdata = read_port(i_rs2_raddr);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && i_rd_waddr != '0) begin
      regs[i_rd_waddr] <= i_rd_wdata; // writes to x0 are dropped
    end
  end
endmodule
`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none
module decode_stage (
  input wire i_clk,
  input wire i_rst,
  input wire i_stall,
  input wire i_flush,
  input wire i_if_valid,
  input wire hart_pkg::word_t i_if_pc,
  input wire hart_pkg::word_t i_if_inst,
  input wire hart_pkg::word_t i_rs1_rdata,
  input wire hart_pkg::word_t i_rs2_rdata,
  output hart_pkg::reg_addr_t o_rs1_raddr,
  output hart_pkg::reg_addr_t o_rs2_raddr,
  output logic o_id_valid,
  output hart_pkg::word_t o_id_pc,
  output hart_pkg::word_t o_id_inst,
  output hart_pkg::word_t o_id_rs1_rdata,
  output hart_pkg::word_t o_id_rs2_rdata,
  output hart_pkg::word_t o_id_imm,
  output hart_pkg::alu_op_e o_id_alu_op,
  output hart_pkg::wb_sel_e o_id_wb_sel,
  output logic o_id_use_imm,
  output logic o_id_use_pc,
  output logic o_id_reg_write,
  output logic o_id_mem_read,
  output logic o_id_mem_write,
  output logic o_id_branch,
  output logic o_id_jal,
  output logic o_id_jalr,
  output hart_pkg::reg_addr_t o_id_rd
);
  logic [6:0] opc;
  logic [2:0] funct3;
  logic alt; // inst bit 30 picks sub and sra
  hart_pkg::alu_op_e alu_fn; // operation named by funct3 and alt
  hart_pkg::alu_op_e alu_op;
  hart_pkg::wb_sel_e wb_sel;
  hart_pkg::word_t imm;
  logic use_imm, use_pc, reg_write, mem_read, mem_write, branch, jal, jalr;

  assign opc = i_if_inst[6:0];
  assign funct3 = i_if_inst[14:12];
  assign alt = i_if_inst[30] && (opc == hart_pkg::OPC_OP || funct3 == 3'b101); // addi never subtracts

  // unread sources report x0 so the hazard unit ignores them
  assign o_rs1_raddr = (i_if_valid && hart_pkg::reads_rs1(opc)) ? i_if_inst[19:15] : '0;
  assign o_rs2_raddr = (i_if_valid && hart_pkg::reads_rs2(opc)) ? i_if_inst[24:20] : '0;

  always_comb begin
    case (funct3)
      3'b000: alu_fn = alt ? hart_pkg::ALU_SUB : hart_pkg::ALU_ADD;
      3'b001: alu_fn = hart_pkg::ALU_SLL;
      3'b010: alu_fn = hart_pkg::ALU_SLT;
      3'b011: alu_fn = hart_pkg::ALU_SLTU;
      3'b100: alu_fn = hart_pkg::ALU_XOR;
      3'b101: alu_fn = alt ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;
      3'b110: alu_fn = hart_pkg::ALU_OR;
      default: alu_fn = hart_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    alu_op = hart_pkg::ALU_ADD; // loads, stores, auipc and addresses all add
    wb_sel = hart_pkg::WB_ALU;
    imm = {{20{i_if_inst[31]}}, i_if_inst[31:20]}; // I form unless replaced below
    {use_imm, use_pc, reg_write, mem_read, mem_write, branch, jal, jalr} = '0;
    case (opc)
      hart_pkg::OPC_OP: begin
        alu_op = alu_fn;
        reg_write = 1'b1;
      end
      hart_pkg::OPC_OP_IMM: begin
        alu_op = alu_fn;
        {use_imm, reg_write} = 2'b11;
      end
      hart_pkg::OPC_LUI, hart_pkg::OPC_AUIPC: begin
        imm = {i_if_inst[31:12], 12'b0};
        alu_op = (opc == hart_pkg::OPC_LUI) ? hart_pkg::ALU_PASS_B : hart_pkg::ALU_ADD;
        use_pc = (opc == hart_pkg::OPC_AUIPC); // auipc adds to its own pc
        {use_imm, reg_write} = 2'b11;
      end
      hart_pkg::OPC_LOAD: begin
        wb_sel = hart_pkg::WB_LOAD;
        {use_imm, reg_write, mem_read} = 3'b111;
      end
      hart_pkg::OPC_STORE: begin
        imm = {{20{i_if_inst[31]}}, i_if_inst[31:25], i_if_inst[11:7]};
        {use_imm, mem_write} = 2'b11;
      end
      hart_pkg::OPC_BRANCH: begin
        imm = {{19{i_if_inst[31]}}, i_if_inst[31], i_if_inst[7], i_if_inst[30:25],
               i_if_inst[11:8], 1'b0};
        branch = 1'b1; // operands stay on registers for the compare
      end
      hart_pkg::OPC_JAL: begin
        imm = {{11{i_if_inst[31]}}, i_if_inst[31], i_if_inst[19:12], i_if_inst[20],
               i_if_inst[30:21], 1'b0};
        wb_sel = hart_pkg::WB_PC4;
        {reg_write, jal} = 2'b11;
      end
      hart_pkg::OPC_JALR: begin
        wb_sel = hart_pkg::WB_PC4;
        {reg_write, jalr} = 2'b11;
      end
      default: ; // system opcodes, ebreak flows through as a no-op
    endcase
  end

  // ID/EX control, a stall, flush or empty slot inserts a bubble
  always_ff @(posedge i_clk) begin
    if (i_rst || i_stall || i_flush || !i_if_valid) begin
      o_id_valid <= 1'b0;
      o_id_inst <= hart_pkg::NOP_INST;
      o_id_rd <= '0;
      {o_id_use_imm, o_id_use_pc, o_id_reg_write, o_id_mem_read} <= '0;
      {o_id_mem_write, o_id_branch, o_id_jal, o_id_jalr} <= '0;
    end else begin
      o_id_valid <= 1'b1;
      o_id_inst <= i_if_inst;
      o_id_rd <= reg_write ? i_if_inst[11:7] : '0; // non-writers report rd zero
      {o_id_use_imm, o_id_use_pc, o_id_reg_write, o_id_mem_read} <=
        {use_imm, use_pc, reg_write, mem_read};
      {o_id_mem_write, o_id_branch, o_id_jal, o_id_jalr} <= {mem_write, branch, jal, jalr};
    end
  end

  always_ff @(posedge i_clk) begin
    o_id_pc <= i_if_pc;
    o_id_rs1_rdata <= i_rs1_rdata;
    o_id_rs2_rdata <= i_rs2_rdata;
    o_id_imm <= imm;
    o_id_alu_op <= alu_op;
    o_id_wb_sel <= wb_sel;
  end
endmodule
`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none
module fetch_stage (
  input wire i_clk,
  input wire i_rst,
  input wire i_stall,
  input wire i_redirect,
  input wire hart_pkg::word_t i_redirect_pc,
  input wire hart_pkg::word_t i_imem_rdata,
  output hart_pkg::word_t o_imem_raddr,
  output logic o_if_valid,
  output hart_pkg::word_t o_if_pc,
  output hart_pkg::word_t o_if_inst
);
  hart_pkg::word_t pc_q; // address of the word the imem returns this cycle
  logic valid_q; // low after reset or redirect while the first word is fetched

  // present the next fetch address combinationally since the imem registers it
  // re-present the held address while stalled or refilling so the imem output stays put
  assign o_imem_raddr = (i_stall || !valid_q) ? pc_q : pc_q + 32'd4;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= hart_pkg::RESET_ADDR;
      valid_q <= 1'b0;
    end else if (i_redirect) begin
      pc_q <= i_redirect_pc; // target is fetched next cycle, two slots are lost
      valid_q <= 1'b0; // redirect wins over a stall
    end else begin
      pc_q <= o_imem_raddr; // equals pc_q itself while stalled
      valid_q <= 1'b1;
    end
  end

  // IF/ID holds pc and valid here, the imem output register is its instruction half
  assign o_if_valid = valid_q;
  assign o_if_pc = pc_q;
  assign o_if_inst = i_imem_rdata;
endmodule
`default_nettype wire

//--- source/hart_pkg.sv
`default_nettype none
package hart_pkg;
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t; // data, address and instruction words
  typedef logic [4:0] reg_addr_t; // register index, x0 reads as zero

  localparam word_t RESET_ADDR = 32'h0000_0000; // first fetch address after reset
  localparam word_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0 fills cleared stages
  localparam word_t EBREAK_INST = 32'h0010_0073; // used only as the halt marker

  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // only ebreak is expected here

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B // lui places the immediate straight on the result
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU, // alu result
    WB_LOAD, // data memory read word
    WB_PC4 // link address of jal and jalr
  } wb_sel_e;

  // true when the opcode reads rs1, decode and retire both rely on this
  function automatic logic reads_rs1(input logic [6:0] opc);
    return opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JALR};
  endfunction

  function automatic logic reads_rs2(input logic [6:0] opc);
    return opc inside {OPC_OP, OPC_STORE, OPC_BRANCH}; // system opcodes read nothing
  endfunction
endpackage
`default_nettype wire
